/* src/uniboard_pkg.sv */
//############################
// protocol constants, bus widths, peripheral map and state types
// UART timing assumes clk_12MHz, so BAUD_DIV of 12 gives 1 Mbaud
// only peripheral 2 (motor PWM) is mapped, all others read as empty
//############################
`default_nettype none

package uniboard_pkg;
	// UART bit period in clock cycles
	localparam int unsigned BAUD_DIV = 12;
	localparam int unsigned BAUD_CNT_W = $clog2(BAUD_DIV);
	// reload values for the bit timers, count down to zero
	localparam logic [BAUD_CNT_W-1:0] BIT_LAST = BAUD_CNT_W'(BAUD_DIV - 1);
	localparam logic [BAUD_CNT_W-1:0] HALF_LAST = BAUD_CNT_W'(BAUD_DIV / 2 - 1);

	// framing bytes
	localparam logic [7:0] BYTE_START = 8'h01;
	localparam logic [7:0] BYTE_END = 8'h17;
	localparam logic [7:0] BYTE_ESC = 8'h1B;

	// command payload, extra bytes beyond this are dropped
	localparam int unsigned MAX_CMD_BYTES = 6;
	localparam int unsigned CMD_CNT_W = $clog2(MAX_CMD_BYTES + 1);
	localparam logic [CMD_CNT_W-1:0] CMD_CNT_MAX = CMD_CNT_W'(MAX_CMD_BYTES);

	// internal peripheral bus
	localparam int unsigned DATA_W = 32;
	localparam int unsigned ADDR_W = 8;
	localparam int unsigned SIZE_W = 3;
	localparam int unsigned PERIPH_W = 7;

	// peripheral map
	localparam logic [PERIPH_W-1:0] PWM_PERIPH = 7'd2;
	localparam logic [ADDR_W-1:0] PWM_ADDR_LEFT = 8'd0;
	localparam logic [ADDR_W-1:0] PWM_ADDR_RIGHT = 8'd1;
	localparam int unsigned PWM_W = 8;

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;
	typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;
	typedef enum logic [1:0] {DEC_IDLE, DEC_IN_FRAME, DEC_ESCAPED} decode_state_t;
	typedef enum logic [2:0] {
		ENG_IDLE, ENG_SETUP, ENG_STROBE, ENG_HOLD, ENG_GAP, ENG_CAPTURE, ENG_REPLY
	} engine_state_t;
	typedef enum logic [2:0] {
		REP_IDLE, REP_SEND, REP_ESC_PENDING, REP_WAIT_BUSY, REP_DONE
	} reply_state_t;
endpackage

`default_nettype wire

/* src/uart_rx.sv */
//############################
// 8N1 receiver, LSB first
// rx must already be synchronous to clk_12MHz
// a frame with a low stop bit is dropped silently
//############################
`default_nettype none

module uart_rx (
	input  logic       clk_12MHz,
	input  logic       reset,
	input  logic       rx,
	output logic [7:0] rx_data,
	output logic       rx_strobe
);
	uniboard_pkg::rx_state_t state;
	logic [uniboard_pkg::BAUD_CNT_W-1:0] timer;
	logic [2:0] bit_idx;

	always_ff @(posedge clk_12MHz)
	begin
		rx_strobe <= 1'b0;
		if (reset)
		begin
			state <= uniboard_pkg::RX_IDLE;
			timer <= '0;
			bit_idx <= '0;
		end
		else if (state == uniboard_pkg::RX_IDLE)
		begin
			// falling edge, aim for the middle of the start bit
			if (!rx)
			begin
				state <= uniboard_pkg::RX_START;
				timer <= uniboard_pkg::HALF_LAST;
			end
		end
		else if (timer != '0)
			timer <= timer - 1'b1;
		else
		begin
			// mid-bit sample point
			timer <= uniboard_pkg::BIT_LAST;
			case (state)
				uniboard_pkg::RX_START:
				begin
					// glitch, not a real start bit
					state <= rx ? uniboard_pkg::RX_IDLE : uniboard_pkg::RX_DATA;
					bit_idx <= '0;
				end
				uniboard_pkg::RX_DATA:
				begin
					rx_data <= {rx, rx_data[7:1]};
					bit_idx <= bit_idx + 1'b1;
					if (bit_idx == 3'd7)
						state <= uniboard_pkg::RX_STOP;
				end
				default:
				begin
					rx_strobe <= rx;
					state <= uniboard_pkg::RX_IDLE;
				end
			endcase
		end
	end

	// decoder counts each pulse as one byte
	assert property (@(posedge clk_12MHz) disable iff (reset) rx_strobe |=> !rx_strobe);
endmodule

`default_nettype wire

/* src/uart_tx.sv */
//############################
// 8N1 transmitter, LSB first
// tx_send is only honoured while tx_busy is low
//############################
`default_nettype none

module uart_tx (
	input  logic       clk_12MHz,
	input  logic       reset,
	input  logic [7:0] tx_data,
	input  logic       tx_send,
	output logic       tx,
	output logic       tx_busy
);
	uniboard_pkg::tx_state_t state;
	logic [uniboard_pkg::BAUD_CNT_W-1:0] timer;
	logic [2:0] bit_idx;
	logic [7:0] shift;

	// high from the cycle after tx_send to the end of the stop bit
	assign tx_busy = (state != uniboard_pkg::TX_IDLE);

	always_ff @(posedge clk_12MHz)
	begin
		if (reset)
		begin
			state <= uniboard_pkg::TX_IDLE;
			tx <= 1'b1;
			timer <= '0;
			bit_idx <= '0;
		end
		else if (state == uniboard_pkg::TX_IDLE)
		begin
			if (tx_send)
			begin
				tx <= 1'b0;
				shift <= tx_data;
				timer <= uniboard_pkg::BIT_LAST;
				state <= uniboard_pkg::TX_START;
			end
		end
		else if (timer != '0)
			timer <= timer - 1'b1;
		else
		begin
			timer <= uniboard_pkg::BIT_LAST;
			case (state)
				uniboard_pkg::TX_START:
				begin
					tx <= shift[0];
					shift <= shift >> 1;
					bit_idx <= '0;
					state <= uniboard_pkg::TX_DATA;
				end
				uniboard_pkg::TX_DATA:
				begin
					// after bit 7 comes the stop bit
					tx <= (bit_idx == 3'd7) ? 1'b1 : shift[0];
					shift <= shift >> 1;
					bit_idx <= bit_idx + 1'b1;
					if (bit_idx == 3'd7)
						state <= uniboard_pkg::TX_STOP;
				end
				default:
					state <= uniboard_pkg::TX_IDLE;
			endcase
		end
	end

	// the encoder must wait out each byte
	assert property (@(posedge clk_12MHz) disable iff (reset) tx_busy |-> !tx_send);
endmodule

`default_nettype wire

/* src/frame_decoder.sv */
//############################
// strips start, end and escape bytes from the host stream
// frames shorter than two bytes are dropped without a strobe
// cmd_* outputs are valid with cmd_strobe until the next start byte
//############################
`default_nettype none

module frame_decoder (
	input  logic                                clk_12MHz,
	input  logic                                reset,
	input  logic [7:0]                          rx_data,
	input  logic                                rx_strobe,
	output logic                                cmd_strobe,
	output logic                                cmd_read,
	output logic [uniboard_pkg::PERIPH_W-1:0]   cmd_periph,
	output logic [uniboard_pkg::ADDR_W-1:0]     cmd_addr,
	output logic [uniboard_pkg::DATA_W-1:0]     cmd_wdata
);
	uniboard_pkg::decode_state_t state;
	logic [uniboard_pkg::CMD_CNT_W-1:0] byte_count;
	logic [7:0] cmd_buf [uniboard_pkg::MAX_CMD_BYTES];
	logic is_start;
	logic is_end;
	logic is_esc;
	logic store;
	logic restart;

	assign is_start = (rx_data == uniboard_pkg::BYTE_START);
	assign is_end = (rx_data == uniboard_pkg::BYTE_END);
	assign is_esc = (rx_data == uniboard_pkg::BYTE_ESC);

	// start byte outside a frame, or a new start inside one
	assign restart = rx_strobe && is_start && (state != uniboard_pkg::DEC_ESCAPED);
	// escaped bytes are always payload
	assign store = rx_strobe && byte_count < uniboard_pkg::CMD_CNT_MAX
		&& ((state == uniboard_pkg::DEC_ESCAPED)
		|| (state == uniboard_pkg::DEC_IN_FRAME && !is_start && !is_end && !is_esc));

	always_ff @(posedge clk_12MHz)
	begin
		cmd_strobe <= 1'b0;
		if (reset)
		begin
			state <= uniboard_pkg::DEC_IDLE;
			byte_count <= '0;
		end
		else if (rx_strobe)
		begin
			if (restart)
			begin
				state <= uniboard_pkg::DEC_IN_FRAME;
				byte_count <= '0;
			end
			else if (state == uniboard_pkg::DEC_ESCAPED)
				state <= uniboard_pkg::DEC_IN_FRAME;
			else if (state == uniboard_pkg::DEC_IN_FRAME)
			begin
				if (is_end)
				begin
					// need at least peripheral and address
					cmd_strobe <= (byte_count >= 2);
					state <= uniboard_pkg::DEC_IDLE;
				end
				else if (is_esc)
					state <= uniboard_pkg::DEC_ESCAPED;
			end
			if (store)
				byte_count <= byte_count + 1'b1;
		end
	end

	// missing write-data bytes read as zero
	always_ff @(posedge clk_12MHz)
	begin
		if (restart)
		begin
			for (int i = 0; i < uniboard_pkg::MAX_CMD_BYTES; i++)
				cmd_buf[i] <= 8'h00;
		end
		else if (store)
			cmd_buf[byte_count] <= rx_data;
	end

	assign cmd_read = cmd_buf[0][7];
	assign cmd_periph = cmd_buf[0][6:0];
	assign cmd_addr = cmd_buf[1];
	assign cmd_wdata = {cmd_buf[5], cmd_buf[4], cmd_buf[3], cmd_buf[2]};

	assert property (@(posedge clk_12MHz) disable iff (reset)
		byte_count <= uniboard_pkg::CMD_CNT_MAX);
endmodule

`default_nettype wire

/* src/command_engine.sv */
//############################
// single bus master, one access per command
// a write is always followed by a readback of the same register
// commands that arrive while busy are dropped
//############################
`default_nettype none

module command_engine (
	input  logic                                clk_12MHz,
	input  logic                                reset,
	input  logic                                cmd_strobe,
	input  logic                                cmd_read,
	input  logic [uniboard_pkg::PERIPH_W-1:0]   cmd_periph,
	input  logic [uniboard_pkg::ADDR_W-1:0]     cmd_addr,
	input  logic [uniboard_pkg::DATA_W-1:0]     cmd_wdata,
	output logic [uniboard_pkg::ADDR_W-1:0]     bus_addr,
	output logic                                bus_rw,
	output logic [uniboard_pkg::DATA_W-1:0]     bus_wdata,
	output logic                                pwm_select,
	input  logic [uniboard_pkg::DATA_W-1:0]     pwm_rdata,
	input  logic [uniboard_pkg::SIZE_W-1:0]     pwm_size,
	output logic                                reply_strobe,
	output logic [7:0]                          reply_head0,
	output logic [7:0]                          reply_head1,
	output logic [uniboard_pkg::DATA_W-1:0]     reply_data,
	output logic [uniboard_pkg::SIZE_W-1:0]     reply_size,
	input  logic                                reply_busy
);
	uniboard_pkg::engine_state_t state;
	logic op_write;
	logic is_pwm;

	always_ff @(posedge clk_12MHz)
	begin
		reply_strobe <= 1'b0;
		if (reset)
		begin
			state <= uniboard_pkg::ENG_IDLE;
			bus_rw <= 1'b1;
			pwm_select <= 1'b0;
			op_write <= 1'b0;
			is_pwm <= 1'b0;
		end
		else
		begin
			case (state)
				uniboard_pkg::ENG_IDLE:
					if (cmd_strobe)
					begin
						op_write <= !cmd_read;
						is_pwm <= (cmd_periph == uniboard_pkg::PWM_PERIPH);
						state <= uniboard_pkg::ENG_SETUP;
					end
				// rw settles a cycle ahead of select
				uniboard_pkg::ENG_SETUP:
				begin
					bus_rw <= !op_write;
					state <= uniboard_pkg::ENG_STROBE;
				end
				// unmapped peripherals never see a select
				uniboard_pkg::ENG_STROBE:
				begin
					pwm_select <= is_pwm;
					state <= uniboard_pkg::ENG_HOLD;
				end
				uniboard_pkg::ENG_HOLD:
					state <= op_write ? uniboard_pkg::ENG_GAP : uniboard_pkg::ENG_CAPTURE;
				// select low before the readback
				uniboard_pkg::ENG_GAP:
				begin
					pwm_select <= 1'b0;
					op_write <= 1'b0;
					state <= uniboard_pkg::ENG_SETUP;
				end
				uniboard_pkg::ENG_CAPTURE:
				begin
					pwm_select <= 1'b0;
					reply_strobe <= 1'b1;
					state <= uniboard_pkg::ENG_REPLY;
				end
				// encoder holds reply_busy until the end byte is queued
				uniboard_pkg::ENG_REPLY:
					if (!reply_busy)
						state <= uniboard_pkg::ENG_IDLE;
				default:
					state <= uniboard_pkg::ENG_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_12MHz)
	begin
		if (state == uniboard_pkg::ENG_IDLE && cmd_strobe)
		begin
			bus_addr <= cmd_addr;
			bus_wdata <= cmd_wdata;
			reply_head0 <= {cmd_read, cmd_periph};
			reply_head1 <= cmd_addr;
		end
		// read data is valid in the last select cycle
		if (state == uniboard_pkg::ENG_CAPTURE)
		begin
			reply_data <= is_pwm ? pwm_rdata : '0;
			reply_size <= is_pwm ? pwm_size : '0;
		end
	end

	assert property (@(posedge clk_12MHz) disable iff (reset)
		pwm_select && $past(pwm_select) |-> $stable(bus_addr) && $stable(bus_rw));
endmodule

`default_nettype wire

/* src/reply_encoder.sv */
//############################
// serializes start, head0, head1, data bytes and end into uart_tx
// at most 4 data bytes are sent, LSB first
// head and data bytes matching a framing byte get an escape first
//############################
`default_nettype none

module reply_encoder (
	input  logic                                clk_12MHz,
	input  logic                                reset,
	input  logic                                reply_strobe,
	input  logic [7:0]                          reply_head0,
	input  logic [7:0]                          reply_head1,
	input  logic [uniboard_pkg::DATA_W-1:0]     reply_data,
	input  logic [uniboard_pkg::SIZE_W-1:0]     reply_size,
	output logic                                reply_busy,
	output logic [7:0]                          tx_data,
	output logic                                tx_send,
	input  logic                                tx_busy
);
	uniboard_pkg::reply_state_t state;
	// 0 start, 1 head0, 2 head1, 3 data then end
	logic [1:0] idx;
	logic [uniboard_pkg::SIZE_W-1:0] data_left;
	logic literal_next;
	logic [7:0] head0_q;
	logic [7:0] head1_q;
	logic [uniboard_pkg::DATA_W-1:0] data_q;
	logic [7:0] cur_byte;
	logic is_marker;
	logic is_end;
	logic load;
	logic send_esc;

	always_comb
	begin
		is_end = (idx == 2'd3) && (data_left == '0);
		is_marker = (idx == 2'd0) || is_end;
		case (idx)
			2'd0: cur_byte = uniboard_pkg::BYTE_START;
			2'd1: cur_byte = head0_q;
			2'd2: cur_byte = head1_q;
			default: cur_byte = is_end ? uniboard_pkg::BYTE_END : data_q[7:0];
		endcase
	end

	assign load = (state == uniboard_pkg::REP_SEND) && !tx_busy;
	assign send_esc = !is_marker && !literal_next
		&& (cur_byte == uniboard_pkg::BYTE_START || cur_byte == uniboard_pkg::BYTE_END
		|| cur_byte == uniboard_pkg::BYTE_ESC);
	// includes the strobe cycle so the engine never sees a gap
	assign reply_busy = (state != uniboard_pkg::REP_IDLE) || reply_strobe;

	always_ff @(posedge clk_12MHz)
	begin
		tx_send <= 1'b0;
		if (reset)
		begin
			state <= uniboard_pkg::REP_IDLE;
			idx <= '0;
			data_left <= '0;
			literal_next <= 1'b0;
		end
		else
		begin
			case (state)
				uniboard_pkg::REP_IDLE:
					if (reply_strobe)
					begin
						idx <= '0;
						data_left <= (reply_size > 3'd4) ? 3'd4 : reply_size;
						literal_next <= 1'b0;
						state <= uniboard_pkg::REP_SEND;
					end
				uniboard_pkg::REP_SEND:
					if (!tx_busy)
					begin
						tx_send <= 1'b1;
						if (send_esc)
							state <= uniboard_pkg::REP_ESC_PENDING;
						else
						begin
							literal_next <= 1'b0;
							state <= is_end ? uniboard_pkg::REP_DONE
								: uniboard_pkg::REP_WAIT_BUSY;
							if (idx != 2'd3)
								idx <= idx + 1'b1;
							else if (data_left != '0)
								data_left <= data_left - 1'b1;
						end
					end
				// wait for the transmitter to take the escape
				uniboard_pkg::REP_ESC_PENDING:
					if (tx_busy)
					begin
						literal_next <= 1'b1;
						state <= uniboard_pkg::REP_SEND;
					end
				uniboard_pkg::REP_WAIT_BUSY:
					if (tx_busy)
						state <= uniboard_pkg::REP_SEND;
				// end byte accepted
				default:
					if (tx_busy)
						state <= uniboard_pkg::REP_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_12MHz)
	begin
		if (state == uniboard_pkg::REP_IDLE && reply_strobe)
		begin
			head0_q <= reply_head0;
			head1_q <= reply_head1;
			data_q <= reply_data;
		end
		else if (load && !send_esc && idx == 2'd3)
			data_q <= data_q >> 8;
		if (load)
			tx_data <= send_esc ? uniboard_pkg::BYTE_ESC : cur_byte;
	end
endmodule

`default_nettype wire

/* src/motor_pwm.sv */
//############################
// two 8-bit duty registers, PWM period 256 clk_12MHz cycles
// writes land on the rising edge of pwm_select
//############################
`default_nettype none

module motor_pwm (
	input  logic                                clk_12MHz,
	input  logic                                reset,
	input  logic [uniboard_pkg::ADDR_W-1:0]     bus_addr,
	input  logic                                bus_rw,
	input  logic [uniboard_pkg::DATA_W-1:0]     bus_wdata,
	input  logic                                pwm_select,
	output logic [uniboard_pkg::DATA_W-1:0]     pwm_rdata,
	output logic [uniboard_pkg::SIZE_W-1:0]     pwm_size,
	output logic                                pwm_left,
	output logic                                pwm_right
);
	logic [uniboard_pkg::PWM_W-1:0] duty_left;
	logic [uniboard_pkg::PWM_W-1:0] duty_right;
	logic [uniboard_pkg::PWM_W-1:0] counter;
	logic select_q;

	always_ff @(posedge clk_12MHz)
	begin
		if (reset)
		begin
			duty_left <= '0;
			duty_right <= '0;
			counter <= '0;
			select_q <= 1'b0;
			pwm_left <= 1'b0;
			pwm_right <= 1'b0;
		end
		else
		begin
			select_q <= pwm_select;
			counter <= counter + 1'b1;
			// high while the counter is below the duty
			pwm_left <= (counter < duty_left);
			pwm_right <= (counter < duty_right);
			if (pwm_select && !select_q && !bus_rw)
			begin
				if (bus_addr == uniboard_pkg::PWM_ADDR_LEFT)
					duty_left <= bus_wdata[uniboard_pkg::PWM_W-1:0];
				else if (bus_addr == uniboard_pkg::PWM_ADDR_RIGHT)
					duty_right <= bus_wdata[uniboard_pkg::PWM_W-1:0];
			end
		end
	end

	// unknown addresses read as size 0, data 0
	always_comb
	begin
		pwm_rdata = '0;
		pwm_size = '0;
		if (pwm_select && bus_rw)
		begin
			if (bus_addr == uniboard_pkg::PWM_ADDR_LEFT)
			begin
				pwm_rdata = {{(uniboard_pkg::DATA_W - uniboard_pkg::PWM_W){1'b0}}, duty_left};
				pwm_size = 3'd1;
			end
			else if (bus_addr == uniboard_pkg::PWM_ADDR_RIGHT)
			begin
				pwm_rdata = {{(uniboard_pkg::DATA_W - uniboard_pkg::PWM_W){1'b0}}, duty_right};
				pwm_size = 3'd1;
			end
		end
	end
endmodule

`default_nettype wire

/* src/uniboard_top.sv */
//############################
// command link top level
// reset comes from outside, synchronous and active high
//############################
`default_nettype none

module uniboard_top (
	input  logic clk_12MHz,
	input  logic reset,
	input  logic uart_rx,
	output logic uart_tx,
	output logic motor_pwm_l,
	output logic motor_pwm_r
);
	logic [7:0] rx_data;
	logic rx_strobe;
	logic cmd_strobe;
	logic cmd_read;
	logic [uniboard_pkg::PERIPH_W-1:0] cmd_periph;
	logic [uniboard_pkg::ADDR_W-1:0] cmd_addr;
	logic [uniboard_pkg::DATA_W-1:0] cmd_wdata;
	logic [uniboard_pkg::ADDR_W-1:0] bus_addr;
	logic bus_rw;
	logic [uniboard_pkg::DATA_W-1:0] bus_wdata;
	logic pwm_select;
	logic [uniboard_pkg::DATA_W-1:0] pwm_rdata;
	logic [uniboard_pkg::SIZE_W-1:0] pwm_size;
	logic reply_strobe;
	logic [7:0] reply_head0;
	logic [7:0] reply_head1;
	logic [uniboard_pkg::DATA_W-1:0] reply_data;
	logic [uniboard_pkg::SIZE_W-1:0] reply_size;
	logic reply_busy;
	logic [7:0] tx_data;
	logic tx_send;
	logic tx_busy;

	uart_rx u_rx (.clk_12MHz, .reset, .rx(uart_rx), .rx_data, .rx_strobe);

	frame_decoder u_decoder (.clk_12MHz, .reset, .rx_data, .rx_strobe, .cmd_strobe,
		.cmd_read, .cmd_periph, .cmd_addr, .cmd_wdata);

	// only bus master
	command_engine u_engine (.clk_12MHz, .reset, .cmd_strobe, .cmd_read, .cmd_periph,
		.cmd_addr, .cmd_wdata, .bus_addr, .bus_rw, .bus_wdata, .pwm_select, .pwm_rdata,
		.pwm_size, .reply_strobe, .reply_head0, .reply_head1, .reply_data, .reply_size,
		.reply_busy);

	// peripheral 2
	motor_pwm u_pwm (.clk_12MHz, .reset, .bus_addr, .bus_rw, .bus_wdata, .pwm_select,
		.pwm_rdata, .pwm_size, .pwm_left(motor_pwm_l), .pwm_right(motor_pwm_r));

	reply_encoder u_encoder (.clk_12MHz, .reset, .reply_strobe, .reply_head0, .reply_head1,
		.reply_data, .reply_size, .reply_busy, .tx_data, .tx_send, .tx_busy);

	uart_tx u_tx (.clk_12MHz, .reset, .tx_data, .tx_send, .tx(uart_tx), .tx_busy);
endmodule

`default_nettype wire

/* test/tb_uniboard.sv */
//############################
// host-side model of the command link
// host UART runs at BAUD_DIV cycles per bit, 8N1
// replies are decoded by a background monitor on uart_tx
// only peripheral 2 is modelled, duties kept in duty_model
//############################
`default_nettype none

module tb_uniboard;
	localparam int TIMEOUT_CYCLES = 40000;
	localparam int REPLY_WAIT = 2000;
	localparam int QUIET_CYCLES = 3000;

	logic clk_12MHz;
	logic reset;
	logic uart_rx;
	logic uart_tx;
	logic motor_pwm_l;
	logic motor_pwm_r;

	integer seed;
	int value_errors;
	int other_errors;
	int cycle_count = 0;
	logic quiet_window;
	logic [7:0] duty_model [2];
	// raw bytes seen on uart_tx
	logic [7:0] mon_bytes [$];
	logic [7:0] payload [$];
	logic [7:0] reply_raw [$];
	logic [7:0] reply_payload [$];
	logic [7:0] exp_payload [$];
	logic [7:0] exp_raw [$];
	logic [7:0] got_bytes [$];
	logic [7:0] exp_bytes [$];

	uniboard_top uut (.clk_12MHz, .reset, .uart_rx, .uart_tx, .motor_pwm_l, .motor_pwm_r);

	initial
	begin
		clk_12MHz = 1'b0;
		forever #5 clk_12MHz = ~clk_12MHz;
	end

	// idle levels after reset
	assert property (@(posedge clk_12MHz) reset |=> uart_tx && !motor_pwm_l && !motor_pwm_r)
	else
	begin
		value_errors++;
		$display("ERROR uart_tx/motor_pwm_l/motor_pwm_r after reset: %s 0x%0h/0x%0h/0x%0h",
			"expected 0x1/0x0/0x0, got", uart_tx, motor_pwm_l, motor_pwm_r);
	end

	// no reply for invalid input
	assert property (@(posedge clk_12MHz) quiet_window |-> uart_tx)
	else
	begin
		other_errors++;
		$display("uart_tx started a byte although no valid command was sent");
	end

	function automatic logic is_framing(input logic [7:0] b);
		return b == uniboard_pkg::BYTE_START || b == uniboard_pkg::BYTE_END
			|| b == uniboard_pkg::BYTE_ESC;
	endfunction

	// one bit period, driven just after the edge
	task automatic drive_bit(input logic level);
		@(posedge clk_12MHz);
		#1 uart_rx = level;
		repeat (uniboard_pkg::BAUD_DIV - 1) @(posedge clk_12MHz);
	endtask

	task automatic send_byte(input logic [7:0] b);
		drive_bit(1'b0);
		for (int i = 0; i < 8; i++)
			drive_bit(b[i]);
		drive_bit(1'b1);
	endtask

	// framed and escaped payload
	task automatic send_frame;
		send_byte(uniboard_pkg::BYTE_START);
		foreach (payload[i])
		begin
			if (is_framing(payload[i]))
				send_byte(uniboard_pkg::BYTE_ESC);
			send_byte(payload[i]);
		end
		send_byte(uniboard_pkg::BYTE_END);
	endtask

	// collect one reply up to an unescaped end byte
	task automatic get_reply;
		int waited;
		logic done;
		logic esc_next;
		logic [7:0] b;
		reply_raw.delete();
		reply_payload.delete();
		waited = 0;
		done = 1'b0;
		esc_next = 1'b0;
		while (!done && waited < REPLY_WAIT)
		begin
			if (mon_bytes.size() > 0)
			begin
				b = mon_bytes.pop_front();
				reply_raw.push_back(b);
				if (esc_next)
				begin
					esc_next = 1'b0;
					reply_payload.push_back(b);
				end
				else if (b == uniboard_pkg::BYTE_ESC)
					esc_next = 1'b1;
				else if (b == uniboard_pkg::BYTE_END)
					done = 1'b1;
				else if (b != uniboard_pkg::BYTE_START)
					reply_payload.push_back(b);
			end
			else
			begin
				@(posedge clk_12MHz);
				waited++;
			end
		end
		if (!done)
		begin
			other_errors++;
			$display("no complete reply frame within %0d cycles", REPLY_WAIT);
		end
	endtask

	task automatic compare_bytes(input string what);
		assert (got_bytes.size() == exp_bytes.size())
		else
		begin
			value_errors++;
			$display("ERROR %s length: expected 0x%0h, got 0x%0h",
				what, exp_bytes.size(), got_bytes.size());
		end
		for (int i = 0; i < exp_bytes.size() && i < got_bytes.size(); i++)
			assert (got_bytes[i] == exp_bytes[i])
			else
			begin
				value_errors++;
				$display("ERROR %s[%0d]: expected 0x%02h, got 0x%02h",
					what, i, exp_bytes[i], got_bytes[i]);
			end
	endtask

	// one command and its reply, expected frame built from the protocol rules
	task automatic run_command(input logic [7:0] head0, input logic [7:0] addr,
		input logic has_wdata, input logic [7:0] wdata,
		input logic has_rdata, input logic [7:0] rdata);
		payload.delete();
		payload.push_back(head0);
		payload.push_back(addr);
		if (has_wdata)
			payload.push_back(wdata);
		send_frame();
		get_reply();
		exp_payload.delete();
		exp_payload.push_back(head0);
		exp_payload.push_back(addr);
		if (has_rdata)
			exp_payload.push_back(rdata);
		exp_raw.delete();
		exp_raw.push_back(uniboard_pkg::BYTE_START);
		foreach (exp_payload[i])
		begin
			if (is_framing(exp_payload[i]))
				exp_raw.push_back(uniboard_pkg::BYTE_ESC);
			exp_raw.push_back(exp_payload[i]);
		end
		exp_raw.push_back(uniboard_pkg::BYTE_END);
		got_bytes = reply_raw;
		exp_bytes = exp_raw;
		compare_bytes("uart_tx frame");
		got_bytes = reply_payload;
		exp_bytes = exp_payload;
		compare_bytes("reply payload");
	endtask

	// side 0 left, 1 right
	task automatic write_duty(input logic side, input logic [7:0] value);
		duty_model[side] = value;
		run_command(8'h02, {7'd0, side}, 1'b1, value, 1'b1, value);
	endtask

	task automatic read_duty(input logic side);
		run_command(8'h82, {7'd0, side}, 1'b0, 8'h00, 1'b1, duty_model[side]);
	endtask

	// one full counter period
	task automatic check_pwm;
		int high_l;
		int high_r;
		high_l = 0;
		high_r = 0;
		repeat (256)
		begin
			@(negedge clk_12MHz);
			if (motor_pwm_l)
				high_l++;
			if (motor_pwm_r)
				high_r++;
		end
		assert (high_l == int'(duty_model[0]))
		else
		begin
			value_errors++;
			$display("ERROR motor_pwm_l high cycles: expected 0x%0h, got 0x%0h",
				duty_model[0], high_l);
		end
		assert (high_r == int'(duty_model[1]))
		else
		begin
			value_errors++;
			$display("ERROR motor_pwm_r high cycles: expected 0x%0h, got 0x%0h",
				duty_model[1], high_r);
		end
	endtask

	// uart_tx decoder, samples at negedge mid-bit
	initial
	begin : uart_monitor
		logic [7:0] shift;
		forever
		begin
			@(negedge clk_12MHz);
			if (uart_tx === 1'b0)
			begin
				repeat (uniboard_pkg::BAUD_DIV / 2) @(negedge clk_12MHz);
				for (int i = 0; i < 8; i++)
				begin
					repeat (uniboard_pkg::BAUD_DIV) @(negedge clk_12MHz);
					shift[i] = uart_tx;
				end
				repeat (uniboard_pkg::BAUD_DIV) @(negedge clk_12MHz);
				assert (uart_tx === 1'b1)
				else
				begin
					other_errors++;
					$display("uart_tx stop bit was low, byte dropped");
				end
				if (uart_tx === 1'b1)
					mon_bytes.push_back(shift);
			end
		end
	end

	initial
	begin : watchdog
		while (cycle_count < TIMEOUT_CYCLES)
		begin
			@(posedge clk_12MHz);
			cycle_count++;
		end
		$display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial
	begin
		seed = 66;
		value_errors = 0;
		other_errors = 0;
		quiet_window = 1'b0;
		uart_rx = 1'b1;
		reset = 1'b1;
		duty_model[0] = 8'h00;
		duty_model[1] = 8'h00;
		repeat (2) @(posedge clk_12MHz);
		#1 reset = 1'b0;
		repeat (20) @(posedge clk_12MHz);

		$display("write with readback");
		write_duty(1'b0, 8'($random(seed)));
		$display("read after write");
		write_duty(1'b1, 8'($random(seed)));
		read_duty(1'b1);

		$display("escaped duties");
		write_duty(1'b0, uniboard_pkg::BYTE_END);
		read_duty(1'b0);
		write_duty(1'b1, uniboard_pkg::BYTE_ESC);
		read_duty(1'b1);
		check_pwm();

		// unmapped peripheral 5, no data bytes and no duty change
		$display("unmapped peripheral");
		run_command(8'h85, 8'h03, 1'b0, 8'h00, 1'b0, 8'h00);
		run_command(8'h05, 8'h00, 1'b1, 8'h5A, 1'b0, 8'h00);
		read_duty(1'b0);
		read_duty(1'b1);

		$display("invalid input");
		@(posedge clk_12MHz);
		#1 quiet_window = 1'b1;
		// stray bytes outside a frame
		send_byte(8'h42);
		send_byte(uniboard_pkg::BYTE_END);
		send_byte(8'h33);
		// frame with a single byte
		send_byte(uniboard_pkg::BYTE_START);
		send_byte(8'h02);
		send_byte(uniboard_pkg::BYTE_END);
		repeat (QUIET_CYCLES) @(posedge clk_12MHz);
		#1 quiet_window = 1'b0;
		assert (mon_bytes.size() == 0)
		else
		begin
			other_errors++;
			$display("bytes arrived on uart_tx after invalid input");
		end
		write_duty(1'b0, 8'($random(seed)));
		write_duty(1'b1, 8'($random(seed)));
		read_duty(1'b0);

		$display("pwm outputs");
		check_pwm();

		$display("errors: %0d value mismatches, %0d other failures",
			value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end
endmodule

`default_nettype wire

/* compile.f */
src/uniboard_pkg.sv
src/uart_rx.sv
src/uart_tx.sv
src/frame_decoder.sv
src/command_engine.sv
src/reply_encoder.sv
src/motor_pwm.sv
src/uniboard_top.sv
test/tb_uniboard.sv

/* run.sh */
#!/bin/sh
# build and run tb_uniboard with Verilator, exit status 1 on any failure
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_uniboard -f compile.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vtb_uniboard > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
	exit 1
fi
exit 0
